//--- tqv_periph.f
source/periph_pkg.sv
source/periph_bus_if.sv
source/bus_ctrl.sv
source/gpio_block.sv
source/pin_mux.sv
source/edge_counter.sv
source/pwm_gen.sv
source/tqv_periph.sv
verification/periph_props.sv
verification/periph_checker.sv
verification/tb_tqv_periph.sv

//--- verification/tb_tqv_periph.sv
// Testbench for the peripheral window. Inputs change on the falling edge,
// the checker samples on the rising edge. PWM pins are predicted only at duty 0.
`timescale 1ns/1ps
`default_nettype none

module tb_tqv_periph;
    import periph_pkg::*;

    localparam int PWM_BITS = 8;
    localparam int PWM_PER  = 1 << PWM_BITS;
    localparam int EDGE_N   = 261;
    // Edge and PWM phases dominate, bus traffic stays well under 600 cycles
    localparam int RUN_LIMIT = 2 * EDGE_N + 2 * PWM_PER + 600;

    localparam logic [1:0] K_DATA  = 2'd0;
    localparam logic [1:0] K_PINS  = 2'd1;
    localparam logic [1:0] K_READY = 2'd2;
    localparam logic [1:0] K_COUNT = 2'd3;

    logic              clk;
    logic              rst_n;
    logic [7:0]        ui_in;
    logic [7:0]        uo_out;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data_in;
    logic [1:0]        write_n;
    logic [1:0]        read_n;
    logic [DATA_W-1:0] data_out;
    logic              data_ready;
    logic              read_complete;
    logic              chk_en;
    logic [1:0]        chk_kind;
    logic [31:0]       chk_exp;
    logic [31:0]       chk_obs;
    int                chk_errors;
    int                chk_count;
    integer            seed;
    int                tb_errors;
    int                test_errors;
    int                cycles;
    int                high;
    logic [31:0]       hold_val;

    // Register model
    logic [7:0]        gpio_out_m;
    func_sel_t         sel_m [8];
    logic [7:0]        edge_cnt_m;
    logic [2:0]        edge_pin_m;
    logic [7:0]        duty_m;

    tqv_periph #(
        .PWM_BITS (PWM_BITS)
    ) uut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .o_uo_out             (uo_out),
        .i_addr               (addr),
        .i_data_in            (data_in),
        .i_data_write_n       (write_n),
        .i_data_read_n        (read_n),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .i_data_read_complete (read_complete)
    );

    periph_checker u_checker (
        .clk          (clk),
        .i_uo_out     (uo_out),
        .i_data_out   (data_out),
        .i_data_ready (data_ready),
        .i_chk_en     (chk_en),
        .i_chk_kind   (chk_kind),
        .i_chk_exp    (chk_exp),
        .i_chk_obs    (chk_obs),
        .o_errors     (chk_errors),
        .o_checks     (chk_count)
    );

    function automatic logic [ADDR_W-1:0] full_addr(input logic [3:0] slot,
                                                    input logic [5:0] ofs);
        return {1'b0, slot, ofs};
    endfunction

    function automatic logic [ADDR_W-1:0] byte_addr(input logic [3:0] slot,
                                                    input logic [3:0] ofs);
        return {3'b100, slot, ofs};
    endfunction

    // Expected read data for an address, from the register model
    function automatic logic [31:0] expected_read(input logic [ADDR_W-1:0] a);
        logic [5:0]  ofs;
        logic [31:0] val;
        ofs = a[5:0];
        val = '0;
        if (!a[10] && a[9:6] == GPIO_SLOT) begin
            if (ofs == GPIO_OUT_OFS) val[7:0] = gpio_out_m;
            else if (ofs == GPIO_IN_OFS) val[7:0] = ui_in;
            else if (ofs[5] && ofs[1:0] == 2'b00) val[4:0] = sel_m[ofs[4:2]];
        end else if (a[10:9] == 2'b10 && a[7:4] == EDGE_SLOT) begin
            if (a[3:0] == 4'h0) val[7:0] = edge_cnt_m;
            else if (a[3:0] == 4'h1) val[2:0] = edge_pin_m;
        end else if (a[10:9] == 2'b10 && a[7:4] == PWM_SLOT && a[3:0] == 4'h0) begin
            val[7:0] = duty_m;
        end
        return val;
    endfunction

    // Expected output pins; a pin routed to the PWM reads low at duty 0
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        pins = '0;
        for (int i = 0; i < 8; i++) begin
            if (sel_m[i].bytes.is_byte) begin
                if (sel_m[i].bytes.byte_idx == EDGE_SLOT) pins[i] = edge_cnt_m[i];
            end else if (sel_m[i].full.full_idx == GPIO_SLOT) begin
                pins[i] = gpio_out_m[i];
            end
        end
        return pins;
    endfunction

    // Failures from the checker, the bus tasks and the bound assertions
    function automatic int error_total();
        return chk_errors + tb_errors + uut.u_bus_ctrl.u_props.fail_count;
    endfunction

    task automatic arm_check(input logic [1:0] kind, input logic [31:0] exp);
        chk_en   = 1'b1;
        chk_kind = kind;
        chk_exp  = exp;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [31:0] d);
        @(negedge clk);
        addr    = a;
        data_in = d;
        write_n = 2'b10;
        // Acknowledge comes in the write's own cycle
        arm_check(K_READY, 32'd1);
        @(negedge clk);
        write_n = NO_ACCESS;
        chk_en  = 1'b0;
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] a);
        int waited;
        waited = 0;
        @(negedge clk);
        addr   = a;
        read_n = 2'b10;
        @(negedge clk);
        while (!data_ready && waited < 8) begin
            waited++;
            @(negedge clk);
        end
        if (!data_ready) begin
            tb_errors++;
            $display("Read of address %h got no data_ready within 8 cycles", a);
        end
        arm_check(K_DATA, expected_read(a));
        read_n        = NO_ACCESS;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        chk_en        = 1'b0;
    endtask

    task automatic check_pins();
        @(negedge clk);
        arm_check(K_PINS, {24'h0, expected_pins()});
        @(negedge clk);
        chk_en = 1'b0;
    endtask

    task automatic set_sel(input int pin, input logic [4:0] v);
        bus_write(full_addr(GPIO_SLOT, GPIO_SEL_BASE + 6'(4 * pin)), {27'h0, v});
        sel_m[pin] = func_sel_t'(v);
        check_pins();
    endtask

    task automatic pulse_pin(input int pin, input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            ui_in[pin] = 1'b1;
            @(negedge clk);
            ui_in[pin] = 1'b0;
        end
        edge_cnt_m = edge_cnt_m + 8'(n);
        // Input register and edge detect delay the count
        repeat (3) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = error_total() - test_errors;
        if (errs == 0) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d error(s)", name, errs);
        end
        test_errors = error_total();
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == RUN_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", RUN_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        seed          = 82;
        rst_n         = 1'b0;
        ui_in         = '0;
        addr          = '0;
        data_in       = '0;
        write_n       = NO_ACCESS;
        read_n        = NO_ACCESS;
        read_complete = 1'b0;
        chk_en        = 1'b0;
        chk_kind      = '0;
        chk_exp       = '0;
        chk_obs       = '0;
        tb_errors     = 0;
        test_errors   = 0;
        gpio_out_m    = '0;
        edge_cnt_m    = '0;
        edge_pin_m    = '0;
        duty_m        = '0;
        for (int i = 0; i < 8; i++) begin
            sel_m[i] = SEL_RESET;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        arm_check(K_READY, 32'd0);
        @(negedge clk);
        chk_en = 1'b0;
        check_pins();
        bus_read(full_addr(GPIO_SLOT, GPIO_OUT_OFS));
        for (int i = 0; i < 8; i++) begin
            bus_read(full_addr(GPIO_SLOT, GPIO_SEL_BASE + 6'(4 * i)));
        end
        finish_test("reset state");

        gpio_out_m = 8'($random(seed));
        bus_write(full_addr(GPIO_SLOT, GPIO_OUT_OFS), {24'h0, gpio_out_m});
        bus_read(full_addr(GPIO_SLOT, GPIO_OUT_OFS));
        check_pins();
        ui_in = 8'($random(seed));
        bus_read(full_addr(GPIO_SLOT, GPIO_IN_OFS));
        // Empty slots swallow writes and read zero
        bus_write(full_addr(4'd3, 6'h00), $random(seed));
        bus_read(full_addr(4'd3, 6'h00));
        bus_write(byte_addr(4'd5, 4'h0), $random(seed));
        bus_read(byte_addr(4'd5, 4'h0));
        finish_test("gpio");

        // Inputs held low while the counter changes pin
        ui_in = '0;
        bus_write(byte_addr(EDGE_SLOT, 4'h1), 32'd3);
        edge_pin_m = 3'd3;
        repeat (3) @(negedge clk);
        bus_write(byte_addr(EDGE_SLOT, 4'h0), 32'hFF);
        edge_cnt_m = '0;
        pulse_pin(3, EDGE_N);
        bus_read(byte_addr(EDGE_SLOT, 4'h0));
        bus_read(byte_addr(EDGE_SLOT, 4'h1));
        bus_write(byte_addr(EDGE_SLOT, 4'h0), 32'h5A);
        edge_cnt_m = '0;
        bus_read(byte_addr(EDGE_SLOT, 4'h0));
        pulse_pin(3, 6);
        bus_read(byte_addr(EDGE_SLOT, 4'h0));
        finish_test("edge counter");

        // GPIO levels opposite to what each rerouted pin shows with count 6
        gpio_out_m = 8'hF9;
        bus_write(full_addr(GPIO_SLOT, GPIO_OUT_OFS), {24'h0, gpio_out_m});
        set_sel(0, {1'b1, EDGE_SLOT});
        set_sel(1, {1'b1, EDGE_SLOT});
        set_sel(2, {1'b1, EDGE_SLOT});
        set_sel(4, {1'b1, PWM_SLOT});
        set_sel(5, {1'b0, 4'd6});
        set_sel(6, {1'b1, 4'd9});
        bus_read(full_addr(GPIO_SLOT, GPIO_SEL_BASE + 6'd24));
        finish_test("function select");

        ui_in = ~gpio_out_m;
        @(negedge clk);
        addr   = full_addr(GPIO_SLOT, GPIO_OUT_OFS);
        read_n = 2'b10;
        arm_check(K_READY, 32'd0);
        @(negedge clk);
        arm_check(K_READY, 32'd1);
        hold_val = expected_read(addr);
        @(negedge clk);
        // Host stalls and moves on, the captured word must stay
        addr = full_addr(GPIO_SLOT, GPIO_IN_OFS);
        arm_check(K_DATA, hold_val);
        repeat (3) @(negedge clk);
        read_n        = NO_ACCESS;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
        chk_en        = 1'b0;
        bus_read(full_addr(GPIO_SLOT, GPIO_IN_OFS));
        finish_test("read handshake");

        duty_m = 8'($random(seed));
        bus_write(byte_addr(PWM_SLOT, 4'h0), {24'h0, duty_m});
        bus_read(byte_addr(PWM_SLOT, 4'h0));
        high = 0;
        for (int c = 0; c < PWM_PER; c++) begin
            @(negedge clk);
            if (uo_out[4]) high++;
        end
        chk_obs = 32'(high);
        arm_check(K_COUNT, {24'h0, duty_m});
        @(negedge clk);
        chk_en = 1'b0;
        finish_test("pwm");

        $display("Checks: %0d, errors: %0d", chk_count, error_total());
        if (error_total() == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/periph_checker.sv
// Compares DUT outputs with the value armed by the testbench.
// Sampling is on the rising edge, before that edge's own updates land.
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input  wire        clk,
    input  wire [7:0]  i_uo_out,
    input  wire [31:0] i_data_out,
    input  wire        i_data_ready,
    input  wire        i_chk_en,
    input  wire [1:0]  i_chk_kind,
    input  wire [31:0] i_chk_exp,
    input  wire [31:0] i_chk_obs,
    output int         o_errors,
    output int         o_checks
);
    localparam logic [1:0] K_DATA  = 2'd0;
    localparam logic [1:0] K_PINS  = 2'd1;
    localparam logic [1:0] K_READY = 2'd2;

    function automatic logic [31:0] observed(input logic [1:0] kind);
        case (kind)
            K_DATA:  return i_data_out;
            K_PINS:  return {24'h0, i_uo_out};
            K_READY: return {31'h0, i_data_ready};
            // High cycles of the PWM pin, counted by the testbench
            default: return i_chk_obs;
        endcase
    endfunction

    function automatic string signal_name(input logic [1:0] kind);
        case (kind)
            K_DATA:  return "o_data_out";
            K_PINS:  return "o_uo_out";
            K_READY: return "o_data_ready";
            default: return "pwm_high_cycles";
        endcase
    endfunction

    initial begin
        o_errors = 0;
        o_checks = 0;
    end

    always @(posedge clk) begin
        if (i_chk_en) begin
            o_checks <= o_checks + 1;
            if (observed(i_chk_kind) !== i_chk_exp) begin
                o_errors <= o_errors + 1;
                $display("[FAIL] t=%0t %s got %h expected %h", $time,
                         signal_name(i_chk_kind), observed(i_chk_kind), i_chk_exp);
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/periph_props.sv
// Handshake assertions, bound into every bus_ctrl instance.
`timescale 1ns/1ps
`default_nettype none

module periph_props (
    input wire        clk,
    input wire        rst_n,
    input wire        read_req,
    input wire        write_req,
    input wire        data_ready,
    input wire        data_hold,
    input wire [31:0] data_out,
    input wire        gpio_rd,
    input wire        edge_rd,
    input wire        pwm_rd
);

    int fail_count = 0;

    // Ready is either a write ack or the result of last cycle's read
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(data_ready) |-> (write_req || $past(read_req)))
        else begin
            fail_count++;
            $error("data_ready rose with no read or write request");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        data_hold |=> $stable(data_out))
        else begin
            fail_count++;
            $error("read data changed while it was held for the host");
        end

    // A read strobe sets the hold flag, which masks the strobes that follow
    assert property (@(posedge clk) disable iff (!rst_n)
        (gpio_rd || edge_rd || pwm_rd)
        |=> (data_hold && !(gpio_rd || edge_rd || pwm_rd)))
        else begin
            fail_count++;
            $error("read strobe reached a peripheral while read data was held");
        end

endmodule

bind bus_ctrl periph_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .read_req   (read_req),
    .write_req  (write_req),
    .data_ready (o_data_ready),
    .data_hold  (data_hold),
    .data_out   (o_data_out),
    .gpio_rd    (gpio_bus.rd),
    .edge_rd    (edge_bus.rd),
    .pwm_rd     (pwm_bus.rd)
);

`default_nettype wire

//--- source/tqv_periph.sv
// Peripheral window top: GPIO in full slot 1, edge counter and PWM in byte slots 0, 1.
// Inputs on i_ui_in are expected to be synchronised already.
`timescale 1ns/1ps
`default_nettype none

module tqv_periph #(
    parameter int PWM_BITS = 8
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [7:0]                    i_ui_in,
    output logic [7:0]                    o_uo_out,
    input  wire  [periph_pkg::ADDR_W-1:0] i_addr,
    input  wire  [periph_pkg::DATA_W-1:0] i_data_in,
    input  wire  [1:0]                    i_data_write_n,
    input  wire  [1:0]                    i_data_read_n,
    output logic [periph_pkg::DATA_W-1:0] o_data_out,
    output logic                          o_data_ready,
    input  wire                           i_data_read_complete
);
    import periph_pkg::*;

    func_sel_t  func_sel [8];
    logic [7:0] gpio_out;
    logic [7:0] edge_out;
    logic [7:0] pwm_out;

    periph_bus_if gpio_bus ();
    periph_bus_if edge_bus ();
    periph_bus_if pwm_bus ();

    bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_data_in            (i_data_in),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .gpio_bus             (gpio_bus.ctrl),
        .edge_bus             (edge_bus.ctrl),
        .pwm_bus              (pwm_bus.ctrl)
    );

    gpio_block u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (gpio_bus.periph),
        .i_ui_in    (i_ui_in),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    edge_counter u_edge_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (edge_bus.periph),
        .i_ui_in  (i_ui_in),
        .o_uo_out (edge_out)
    );

    pwm_gen #(
        .PWM_BITS (PWM_BITS)
    ) u_pwm (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (pwm_bus.periph),
        .o_uo_out (pwm_out)
    );

    pin_mux u_pin_mux (
        .i_func_sel (func_sel),
        .i_gpio_out (gpio_out),
        .i_edge_out (edge_out),
        .i_pwm_out  (pwm_out),
        .o_uo_out   (o_uo_out)
    );

endmodule

`default_nettype wire

//--- source/pwm_gen.sv
// Free-running PWM, period 2^PWM_BITS cycles, high while counter < duty.
// Only the low 8 duty bits are reachable through the byte bus.
`timescale 1ns/1ps
`default_nettype none

module pwm_gen #(
    parameter int PWM_BITS = 8
) (
    input  wire          clk,
    input  wire          rst_n,
    periph_bus_if.periph bus,
    output logic [7:0]   o_uo_out
);
    import periph_pkg::*;

    localparam logic [5:0] DUTY_OFS = 6'd0;

    logic [PWM_BITS-1:0] duty;
    logic [PWM_BITS-1:0] cnt;
    logic                pwm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
            cnt  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            if (bus.wr && bus.offset == DUTY_OFS) begin
                duty <= bus.wdata[PWM_BITS-1:0];
            end
        end
    end

    assign pwm = cnt < duty;

    always_comb begin
        bus.rdata = '0;
        if (bus.rd && bus.offset == DUTY_OFS) begin
            bus.rdata = DATA_W'(duty);
        end
    end

    assign bus.ready = 1'b1;
    assign o_uo_out  = {8{pwm}};

endmodule

`default_nettype wire

//--- source/edge_counter.sv
// Byte slot counting rising edges on one input pin. Count wraps at 256.
// Changing the pin index may register one spurious edge.
`timescale 1ns/1ps
`default_nettype none

module edge_counter (
    input  wire          clk,
    input  wire          rst_n,
    periph_bus_if.periph bus,
    input  wire  [7:0]   i_ui_in,
    output logic [7:0]   o_uo_out
);
    localparam logic [5:0] CNT_OFS = 6'd0;
    localparam logic [5:0] PIN_OFS = 6'd1;

    logic [7:0] count;
    logic [2:0] pin_idx;
    logic       pin_q;
    logic       pin_prev;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count    <= '0;
            pin_idx  <= '0;
            pin_q    <= 1'b0;
            pin_prev <= 1'b0;
        end else begin
            pin_q    <= i_ui_in[pin_idx];
            pin_prev <= pin_q;
            // Clear wins over a coincident edge
            if (bus.wr && bus.offset == CNT_OFS) begin
                count <= '0;
            end else if (pin_q && !pin_prev) begin
                count <= count + 8'd1;
            end
            if (bus.wr && bus.offset == PIN_OFS) begin
                pin_idx <= bus.wdata[2:0];
            end
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (bus.rd && bus.offset == CNT_OFS) begin
            bus.rdata = {24'h0, count};
        end else if (bus.rd && bus.offset == PIN_OFS) begin
            bus.rdata = {29'h0, pin_idx};
        end
    end

    assign bus.ready = 1'b1;
    assign o_uo_out  = count;

endmodule

`default_nettype wire

//--- source/pin_mux.sv
// Output pin routing. Each pin takes its own bit position from the named slot.
`timescale 1ns/1ps
`default_nettype none

module pin_mux (
    input  wire periph_pkg::func_sel_t i_func_sel [8],
    input  wire [7:0]                  i_gpio_out,
    input  wire [7:0]                  i_edge_out,
    input  wire [7:0]                  i_pwm_out,
    output logic [7:0]                 o_uo_out
);
    import periph_pkg::*;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            o_uo_out[i] = 1'b0;
            if (i_func_sel[i].bytes.is_byte) begin
                case (i_func_sel[i].bytes.byte_idx)
                    EDGE_SLOT: o_uo_out[i] = i_edge_out[i];
                    PWM_SLOT:  o_uo_out[i] = i_pwm_out[i];
                    default:   o_uo_out[i] = 1'b0;
                endcase
            end else if (i_func_sel[i].full.full_idx == GPIO_SLOT) begin
                o_uo_out[i] = i_gpio_out[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/gpio_block.sv
// GPIO slot: output byte, input readback and eight pin function selects.
// Writes use the low bits of the data word whatever the access size.
`timescale 1ns/1ps
`default_nettype none

module gpio_block (
    input  wire                    clk,
    input  wire                    rst_n,
    periph_bus_if.periph           bus,
    input  wire  [7:0]             i_ui_in,
    output logic [7:0]             o_gpio_out,
    output periph_pkg::func_sel_t  o_func_sel [8]
);
    import periph_pkg::*;

    logic [7:0] gpio_out;
    func_sel_t  func_sel [8];
    logic       sel_hit;
    logic [2:0] sel_idx;

    // Selects sit at 0x20 + 4*i, word aligned
    assign sel_hit = (bus.offset[5] == GPIO_SEL_BASE[5]) && (bus.offset[1:0] == 2'b00);
    assign sel_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
        end else if (bus.wr && bus.offset == GPIO_OUT_OFS) begin
            gpio_out <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                func_sel[i] <= SEL_RESET;
            end
        end else if (bus.wr && sel_hit) begin
            func_sel[sel_idx] <= func_sel_t'(bus.wdata[4:0]);
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (bus.rd) begin
            if (bus.offset == GPIO_OUT_OFS) begin
                bus.rdata = {24'h0, gpio_out};
            end else if (bus.offset == GPIO_IN_OFS) begin
                bus.rdata = {24'h0, i_ui_in};
            end else if (sel_hit) begin
                bus.rdata = {27'h0, func_sel[sel_idx]};
            end
        end
    end

    assign bus.ready = 1'b1;

    assign o_gpio_out = gpio_out;
    assign o_func_sel = func_sel;

endmodule

`default_nettype wire

//--- source/bus_ctrl.sv
// Host side of the peripheral window. One read may be outstanding and the
// host must pulse read_complete before the next one. Upper full region reads zero.
`timescale 1ns/1ps
`default_nettype none

module bus_ctrl (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire  [periph_pkg::ADDR_W-1:0] i_addr,
    input  wire  [1:0]                    i_data_write_n,
    input  wire  [1:0]                    i_data_read_n,
    input  wire                           i_data_read_complete,
    input  wire  [periph_pkg::DATA_W-1:0] i_data_in,
    output logic [periph_pkg::DATA_W-1:0] o_data_out,
    output logic                          o_data_ready,
    periph_bus_if.ctrl                    gpio_bus,
    periph_bus_if.ctrl                    edge_bus,
    periph_bus_if.ctrl                    pwm_bus
);
    import periph_pkg::*;

    logic              read_req;
    logic              write_req;
    logic              byte_rgn;
    logic              full_rgn;
    logic              sel_gpio;
    logic              sel_edge;
    logic              sel_pwm;
    logic              rd_open;
    logic [DATA_W-1:0] rdata_sel;
    logic              ready_sel;
    logic              capture;
    logic [DATA_W-1:0] data_out_r;
    logic              data_hold;
    logic              data_ready_r;

    assign read_req  = i_data_read_n != NO_ACCESS;
    assign write_req = i_data_write_n != NO_ACCESS;

    // Full slots are 64 bytes from 0x000, byte slots 16 bytes from 0x400
    assign byte_rgn = i_addr[10:9] == BYTE_RGN;
    assign full_rgn = !i_addr[10];

    assign sel_gpio = full_rgn && (i_addr[9:6] == GPIO_SLOT);
    assign sel_edge = byte_rgn && (i_addr[7:4] == EDGE_SLOT);
    assign sel_pwm  = byte_rgn && (i_addr[7:4] == PWM_SLOT);

    // Read strobes stay masked while a result waits for the host
    assign rd_open = read_req && !data_hold;

    assign gpio_bus.offset = i_addr[5:0];
    assign gpio_bus.wdata  = i_data_in;
    assign gpio_bus.wr     = write_req && sel_gpio;
    assign gpio_bus.rd     = rd_open && sel_gpio;

    assign edge_bus.offset = {2'b00, i_addr[3:0]};
    assign edge_bus.wdata  = i_data_in;
    assign edge_bus.wr     = write_req && sel_edge;
    assign edge_bus.rd     = rd_open && sel_edge;

    assign pwm_bus.offset = {2'b00, i_addr[3:0]};
    assign pwm_bus.wdata  = i_data_in;
    assign pwm_bus.wr     = write_req && sel_pwm;
    assign pwm_bus.rd     = rd_open && sel_pwm;

    // Empty slots answer at once with zero
    always_comb begin
        rdata_sel = '0;
        ready_sel = 1'b1;
        if (sel_gpio) begin
            rdata_sel = gpio_bus.rdata;
            ready_sel = gpio_bus.ready;
        end else if (sel_edge) begin
            rdata_sel = edge_bus.rdata;
            ready_sel = edge_bus.ready;
        end else if (sel_pwm) begin
            rdata_sel = pwm_bus.rdata;
            ready_sel = pwm_bus.ready;
        end
    end

    assign capture = rd_open && ready_sel;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold    <= 1'b0;
            data_ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            if (capture) begin
                data_hold <= 1'b1;
            end
            // Registered along with the data it qualifies
            data_ready_r <= read_req && ready_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_r <= rdata_sel;
        end
    end

    assign o_data_out   = data_out_r;
    assign o_data_ready = data_ready_r || write_req;

endmodule

`default_nettype wire

//--- source/periph_bus_if.sv
// Internal bus for one slot. Strobes are single cycle and slot qualified.
// Read data must be zero when rd is low.
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
    import periph_pkg::*;

    logic [FULL_OFS_W-1:0] offset;
    logic [DATA_W-1:0]     wdata;
    logic                  wr;
    logic                  rd;
    logic [DATA_W-1:0]     rdata;
    logic                  ready;

    modport ctrl (
        output offset,
        output wdata,
        output wr,
        output rd,
        input  rdata,
        input  ready
    );

    modport periph (
        input  offset,
        input  wdata,
        input  wr,
        input  rd,
        output rdata,
        output ready
    );

endinterface

`default_nettype wire

//--- source/periph_pkg.sv
// Address map and shared types for the peripheral window.
// Only full slot 1 and byte slots 0 and 1 are populated.
`default_nettype none

package periph_pkg;

    localparam int ADDR_W     = 11;
    localparam int DATA_W     = 32;
    localparam int FULL_OFS_W = 6;

    // Size-coded strobe, 00/01/10 are byte/half/word
    localparam logic [1:0] NO_ACCESS = 2'b11;

    // addr[10:9] of the byte slot region at 0x400
    localparam logic [1:0] BYTE_RGN = 2'b10;

    localparam logic [3:0] GPIO_SLOT = 4'd1;
    localparam logic [3:0] EDGE_SLOT = 4'd0;
    localparam logic [3:0] PWM_SLOT  = 4'd1;

    localparam logic [FULL_OFS_W-1:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [FULL_OFS_W-1:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [FULL_OFS_W-1:0] GPIO_SEL_BASE = 6'h20;

    typedef struct packed {
        logic       is_byte;
        logic [3:0] full_idx;
    } full_view_t;

    typedef struct packed {
        logic       is_byte;
        logic [3:0] byte_idx;
    } byte_view_t;

    // Pin function select, the top bit picks which view applies
    typedef union packed {
        full_view_t full;
        byte_view_t bytes;
    } func_sel_t;

    localparam func_sel_t SEL_RESET = func_sel_t'({1'b0, GPIO_SLOT});

endpackage

`default_nettype wire
